// File: hdl/ack_generator.sv
`timescale 1ns/1ns
`default_nettype none

module ack_generator (
	input wire clk,
	input wire rst,
	input wire gen_ack,
	input wire gen_nak,
	input wire [7:0] eid,
	output logic [7:0] ag_data,
	output logic ag_data_latch,
	output logic ag_frame_valid,
	output logic ag_busy
);
	import settings_pkg::*;

	localparam logic [1:0] AG_IDLE = 2'd0;
	localparam logic [1:0] AG_CODE = 2'd1;
	localparam logic [1:0] AG_EID = 2'd2;

	logic [1:0] step;
	logic [7:0] code_q;
	logic [7:0] eid_q;
	logic start;

	assign start = (step == AG_IDLE) && (gen_ack || gen_nak);

	always_ff @(posedge clk) begin
		if (rst) begin
			step <= AG_IDLE;
		end else begin
			case (step)
				AG_IDLE: if (start) step <= AG_CODE;
				AG_CODE: step <= AG_EID;
				default: step <= AG_IDLE;
			endcase
		end
	end

	// NAK wins if both requests show up together
	always_ff @(posedge clk) begin
		if (start) begin
			code_q <= gen_nak ? NAK_CODE : ACK_CODE;
			eid_q <= eid;
		end
	end

	assign ag_data = (step == AG_EID) ? eid_q : code_q;
	assign ag_data_latch = (step == AG_CODE) || (step == AG_EID);
	// Frame valid drops right after the EID byte, which commits the frame
	assign ag_frame_valid = ag_data_latch;
	assign ag_busy = (step != AG_IDLE);

endmodule

`default_nettype wire

// File: hdl/frame_receiver.sv
`timescale 1ns/1ns
`default_nettype none

module frame_receiver (
	input wire clk,
	input wire rst,
	input wire [7:0] in_data,
	input wire in_data_valid,
	input wire in_frame_valid,
	output logic [7:0] cmd_byte,
	output logic cmd_start,
	output logic [7:0] pay_data,
	output logic pay_valid
);

	logic last_frame_valid;
	logic frame_rise;

	// The byte on the bus in the rising cycle is the command, valid or not
	assign frame_rise = in_frame_valid && !last_frame_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			last_frame_valid <= 1'b0;
			cmd_start <= 1'b0;
			pay_valid <= 1'b0;
		end else begin
			last_frame_valid <= in_frame_valid;
			cmd_start <= frame_rise;
			// Command byte never shows up as payload
			pay_valid <= in_frame_valid && in_data_valid && !frame_rise;
		end
	end

	always_ff @(posedge clk) begin
		if (frame_rise) begin
			cmd_byte <= in_data;
		end
		pay_data <= in_data;
	end

endmodule

`default_nettype wire

// File: hdl/message_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module message_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input wire clk,
	input wire rst,
	input wire [7:0] wr_data,
	input wire wr_latch,
	input wire wr_frame_valid,
	input wire out_credit,
	output logic [7:0] out_data,
	output logic out_valid,
	output logic out_last,
	output logic fifo_room,
	output logic fifo_empty
);
	import settings_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW:0] DEPTH = (AW+1)'(FIFO_DEPTH);
	localparam logic [AW:0] PTR_ONE = (AW+1)'(1);
	localparam logic [AW:0] ROOM_MIN = (AW+1)'(RESP_MAX_BYTES);

	logic [7:0] mem [FIFO_DEPTH];
	logic eof [FIFO_DEPTH];

	// Extra pointer bit tells full from empty
	logic [AW:0] wr_ptr, tail_ptr, rd_ptr;
	logic [AW:0] used;
	logic [AW-1:0] last_idx;
	logic last_frame_valid;
	logic [7:0] credits;
	logic wr_ok, commit, send, grant;

	assign used = wr_ptr - rd_ptr;
	assign last_idx = wr_ptr[AW-1:0] - AW'(1);
	assign wr_ok = wr_latch && (used != DEPTH);
	// Falling frame valid closes the frame that was just written
	assign commit = last_frame_valid && !wr_frame_valid && (wr_ptr != tail_ptr);
	// Only committed bytes may leave, one per credit
	assign send = (credits != 8'd0) && (rd_ptr != tail_ptr);
	assign grant = out_credit && ((credits != 8'hFF) || send);

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fifo_room = (DEPTH - used) >= ROOM_MIN;

	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr[AW-1:0]] <= wr_data;
			eof[wr_ptr[AW-1:0]] <= 1'b0;
		end
		if (commit)
			eof[last_idx] <= 1'b1;
		if (send) begin
			out_data <= mem[rd_ptr[AW-1:0]];
			out_last <= eof[rd_ptr[AW-1:0]];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			tail_ptr <= '0;
			rd_ptr <= '0;
			last_frame_valid <= 1'b0;
			credits <= 8'd0;
			out_valid <= 1'b0;
		end else begin
			last_frame_valid <= wr_frame_valid;
			if (wr_ok)
				wr_ptr <= wr_ptr + PTR_ONE;
			if (commit)
				tail_ptr <= wr_ptr;
			if (send)
				rd_ptr <= rd_ptr + PTR_ONE;
			out_valid <= send;
			case ({grant, send})
				2'b10: credits <= credits + 8'd1;
				2'b01: credits <= credits - 8'd1;
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: hdl/settings_pkg.sv
`default_nettype none

package settings_pkg;

	// Command bytes
	localparam logic [7:0] CMD_VERSION = 8'h76;
	localparam logic [7:0] CMD_QUERY_I2C = 8'h49;
	localparam logic [7:0] CMD_SET_I2C = 8'h69;
	localparam logic [7:0] CMD_QUERY_GPIO = 8'h47;
	localparam logic [7:0] CMD_SET_GPIO = 8'h67;

	// Selector bytes, sent right after the length byte
	localparam logic [7:0] SEL_I2C_SPEED = 8'h63;
	localparam logic [7:0] SEL_I2C_ADDR = 8'h61;
	localparam logic [7:0] SEL_GPIO_LEVEL = 8'h6c;
	localparam logic [7:0] SEL_GPIO_DIR = 8'h64;

	// First byte of every reply frame
	localparam logic [7:0] ACK_CODE = 8'h61;
	localparam logic [7:0] NAK_CODE = 8'h6e;

	// Setting values out of reset
	localparam logic [7:0] I2C_SPEED_RESET = 8'd99;
	localparam logic [15:0] I2C_ADDR_RESET = 16'hFFFF;
	localparam logic [23:0] GPIO_RESET = 24'h000000;

	// Worst case per command is a two byte ACK plus three data bytes
	localparam logic [2:0] RESP_MAX_BYTES = 3'd5;

endpackage

`default_nettype wire

// File: hdl/settings_processor.sv
`timescale 1ns/1ns
`default_nettype none

module settings_processor #(
	parameter logic [7:0] VERSION_MAJOR = 8'h00,
	parameter logic [7:0] VERSION_MINOR = 8'h02
) (
	input wire clk,
	input wire rst,
	input wire [7:0] cmd_byte,
	input wire cmd_start,
	input wire [7:0] pay_data,
	input wire pay_valid,
	input wire nak_request,
	input wire fifo_room,
	input wire fifo_empty,
	input wire ag_busy,
	input wire [23:0] gpio_read,
	output logic gen_ack,
	output logic gen_nak,
	output logic [7:0] eid,
	output logic [7:0] wr_data,
	output logic wr_latch,
	output logic wr_frame_valid,
	output logic [7:0] i2c_speed,
	output logic [15:0] i2c_addr,
	output logic [23:0] gpio_level,
	output logic [23:0] gpio_direction
);
	import settings_pkg::*;

	// Staging holds every data byte of a reply that follows the ACK
	localparam int STAGE_BITS = 8 * (RESP_MAX_BYTES - 2);

	localparam logic [3:0] S_IDLE = 4'd0;
	localparam logic [3:0] S_EID = 4'd1;
	localparam logic [3:0] S_LEN = 4'd2;
	localparam logic [3:0] S_NAK = 4'd3;
	localparam logic [3:0] S_VER_IN = 4'd4;
	localparam logic [3:0] S_VER_CHK = 4'd5;
	localparam logic [3:0] S_SEL = 4'd6;
	localparam logic [3:0] S_WAIT = 4'd7;
	localparam logic [3:0] S_SEND = 4'd8;
	localparam logic [3:0] S_SET_IN = 4'd9;
	localparam logic [3:0] S_SET_ACK = 4'd10;
	localparam logic [3:0] S_SET_WAIT = 4'd11;

	localparam logic [1:0] T_SPEED = 2'd0;
	localparam logic [1:0] T_ADDR = 2'd1;
	localparam logic [1:0] T_LEVEL = 2'd2;
	localparam logic [1:0] T_DIR = 2'd3;

	logic [3:0] state, next_state;
	logic nak_mode;
	logic [1:0] byte_cnt;
	logic [7:0] cmd_q;
	logic [15:0] version_in;
	logic [STAGE_BITS-1:0] staging;
	logic [1:0] target;
	logic [23:0] level_temp, dir_temp;
	logic cmd_known, is_query;
	logic sel_ok;
	logic [1:0] sel_target, sel_count;
	logic [STAGE_BITS-1:0] query_word;

	assign cmd_known = (cmd_byte == CMD_VERSION) || (cmd_byte == CMD_QUERY_I2C) ||
		(cmd_byte == CMD_SET_I2C) || (cmd_byte == CMD_QUERY_GPIO) ||
		(cmd_byte == CMD_SET_GPIO);
	assign is_query = (cmd_q == CMD_QUERY_I2C) || (cmd_q == CMD_QUERY_GPIO);

	// Selector decode, only looked at while in S_SEL
	always_comb begin
		sel_ok = 1'b0;
		sel_target = T_SPEED;
		sel_count = 2'd1;
		if ((cmd_q == CMD_QUERY_I2C) || (cmd_q == CMD_SET_I2C)) begin
			if (pay_data == SEL_I2C_SPEED) begin
				sel_ok = 1'b1;
			end else if (pay_data == SEL_I2C_ADDR) begin
				sel_ok = 1'b1;
				sel_target = T_ADDR;
				sel_count = 2'd2;
			end
		end else if (pay_data == SEL_GPIO_LEVEL) begin
			sel_ok = 1'b1;
			sel_target = T_LEVEL;
			sel_count = 2'd3;
		end else if (pay_data == SEL_GPIO_DIR) begin
			sel_ok = 1'b1;
			sel_target = T_DIR;
			sel_count = 2'd3;
		end
		// Left aligned so the MSB goes out first
		case (sel_target)
			T_SPEED: query_word = {i2c_speed, 16'h0000};
			T_ADDR: query_word = {i2c_addr, 8'h00};
			T_LEVEL: query_word = gpio_read;
			default: query_word = gpio_direction;
		endcase
	end

	always_comb begin
		next_state = state;
		gen_ack = 1'b0;
		gen_nak = 1'b0;
		case (state)
			S_IDLE: begin
				// No room for a full reply means the command is lost
				if (fifo_room && (nak_request || (cmd_start && cmd_known)))
					next_state = S_EID;
			end
			S_EID: if (pay_valid) next_state = S_LEN;
			S_LEN: begin
				if (pay_valid) begin
					if (nak_mode)
						next_state = S_NAK;
					else if (cmd_q == CMD_VERSION)
						next_state = S_VER_IN;
					else
						next_state = S_SEL;
				end
			end
			S_NAK: begin
				gen_nak = 1'b1;
				next_state = S_IDLE;
			end
			S_VER_IN: if (pay_valid && byte_cnt == 2'd1) next_state = S_VER_CHK;
			S_VER_CHK: begin
				if (version_in == {VERSION_MAJOR, VERSION_MINOR}) begin
					gen_ack = 1'b1;
					next_state = S_IDLE;
				end else begin
					// NAK, then a second frame with our own version
					gen_nak = 1'b1;
					next_state = S_WAIT;
				end
			end
			S_SEL: begin
				if (pay_valid) begin
					if (!sel_ok) begin
						next_state = S_IDLE;
					end else if (is_query) begin
						gen_ack = 1'b1;
						next_state = S_WAIT;
					end else begin
						next_state = S_SET_IN;
					end
				end
			end
			// Frame valid stays low here so the ACK frame gets committed first
			S_WAIT: if (!ag_busy) next_state = S_SEND;
			S_SEND: if (byte_cnt == 2'd1) next_state = S_IDLE;
			S_SET_IN: if (pay_valid && byte_cnt == 2'd1) next_state = S_SET_ACK;
			S_SET_ACK: begin
				gen_ack = 1'b1;
				next_state = S_SET_WAIT;
			end
			// Hold GPIO changes until the ACK has drained out
			S_SET_WAIT: if (!ag_busy && fifo_empty) next_state = S_IDLE;
			default: next_state = S_IDLE;
		endcase
	end

	assign wr_data = staging[STAGE_BITS-1 -: 8];
	assign wr_latch = (state == S_SEND);
	assign wr_frame_valid = (state == S_SEND);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			nak_mode <= 1'b0;
			byte_cnt <= 2'd0;
			i2c_speed <= I2C_SPEED_RESET;
			i2c_addr <= I2C_ADDR_RESET;
			gpio_level <= GPIO_RESET;
			gpio_direction <= GPIO_RESET;
		end else begin
			state <= next_state;
			if (state == S_IDLE)
				nak_mode <= nak_request;
			case (state)
				S_LEN, S_VER_CHK: byte_cnt <= 2'd2;
				S_VER_IN, S_SET_IN: if (pay_valid) byte_cnt <= byte_cnt - 2'd1;
				S_SEL: byte_cnt <= sel_count;
				S_SEND: byte_cnt <= byte_cnt - 2'd1;
				default: ;
			endcase
			// I2C settings take effect byte by byte
			if (state == S_SET_IN && pay_valid) begin
				if (target == T_SPEED)
					i2c_speed <= pay_data;
				else if (target == T_ADDR)
					i2c_addr <= {i2c_addr[7:0], pay_data};
			end
			if (state == S_SET_WAIT && next_state == S_IDLE) begin
				if (target == T_LEVEL)
					gpio_level <= level_temp;
				else if (target == T_DIR)
					gpio_direction <= dir_temp;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && cmd_start)
			cmd_q <= cmd_byte;
		if (state == S_EID && pay_valid)
			eid <= pay_data;
		if (state == S_VER_IN && pay_valid)
			version_in <= {version_in[7:0], pay_data};
		if (state == S_SEL)
			target <= sel_target;
		if (state == S_VER_CHK)
			staging <= {VERSION_MAJOR, VERSION_MINOR, 8'h00};
		else if (state == S_SEL)
			staging <= query_word;
		else if (state == S_SEND)
			staging <= {staging[STAGE_BITS-9:0], 8'h00};
		if (state == S_SET_IN && pay_valid) begin
			if (target == T_LEVEL)
				level_temp <= {level_temp[15:0], pay_data};
			if (target == T_DIR)
				dir_temp <= {dir_temp[15:0], pay_data};
		end
	end

endmodule

`default_nettype wire

// File: hdl/settings_top.sv
`timescale 1ns/1ns
`default_nettype none

module settings_top #(
	parameter logic [7:0] VERSION_MAJOR = 8'h00,
	parameter logic [7:0] VERSION_MINOR = 8'h02,
	parameter int FIFO_DEPTH = 16
) (
	input wire clk,
	input wire rst,
	input wire [7:0] in_data,
	input wire in_data_valid,
	input wire in_frame_valid,
	input wire nak_request,
	output wire [7:0] out_data,
	output wire out_valid,
	output wire out_last,
	input wire out_credit,
	input wire [23:0] gpio_read,
	output wire [7:0] i2c_speed,
	output wire [15:0] i2c_addr,
	output wire [23:0] gpio_level,
	output wire [23:0] gpio_direction
);

	wire [7:0] cmd_byte, pay_data, eid;
	wire cmd_start, pay_valid;
	wire gen_ack, gen_nak;
	wire [7:0] ag_data, proc_wr_data;
	wire ag_data_latch, ag_frame_valid, ag_busy;
	wire proc_wr_latch, proc_wr_frame_valid;
	wire fifo_room, fifo_empty;

	// ACK bytes take the write port, the processor stays off it while busy
	wire [7:0] wr_data = ag_data_latch ? ag_data : proc_wr_data;
	wire wr_latch = ag_data_latch || proc_wr_latch;
	wire wr_frame_valid = ag_frame_valid || proc_wr_frame_valid;

	frame_receiver rx (
		.clk(clk), .rst(rst),
		.in_data(in_data), .in_data_valid(in_data_valid), .in_frame_valid(in_frame_valid),
		.cmd_byte(cmd_byte), .cmd_start(cmd_start),
		.pay_data(pay_data), .pay_valid(pay_valid)
	);

	settings_processor #(
		.VERSION_MAJOR(VERSION_MAJOR),
		.VERSION_MINOR(VERSION_MINOR)
	) proc (
		.clk(clk), .rst(rst),
		.cmd_byte(cmd_byte), .cmd_start(cmd_start),
		.pay_data(pay_data), .pay_valid(pay_valid),
		.nak_request(nak_request), .fifo_room(fifo_room), .fifo_empty(fifo_empty),
		.ag_busy(ag_busy), .gpio_read(gpio_read),
		.gen_ack(gen_ack), .gen_nak(gen_nak), .eid(eid),
		.wr_data(proc_wr_data), .wr_latch(proc_wr_latch), .wr_frame_valid(proc_wr_frame_valid),
		.i2c_speed(i2c_speed), .i2c_addr(i2c_addr),
		.gpio_level(gpio_level), .gpio_direction(gpio_direction)
	);

	ack_generator ag (
		.clk(clk), .rst(rst),
		.gen_ack(gen_ack), .gen_nak(gen_nak), .eid(eid),
		.ag_data(ag_data), .ag_data_latch(ag_data_latch),
		.ag_frame_valid(ag_frame_valid), .ag_busy(ag_busy)
	);

	message_fifo #(
		.FIFO_DEPTH(FIFO_DEPTH)
	) mf (
		.clk(clk), .rst(rst),
		.wr_data(wr_data), .wr_latch(wr_latch), .wr_frame_valid(wr_frame_valid),
		.out_credit(out_credit),
		.out_data(out_data), .out_valid(out_valid), .out_last(out_last),
		.fifo_room(fifo_room), .fifo_empty(fifo_empty)
	);

endmodule

`default_nettype wire

// File: list.f
hdl/settings_pkg.sv
hdl/frame_receiver.sv
hdl/ack_generator.sv
hdl/settings_processor.sv
hdl/message_fifo.sv
hdl/settings_top.sv
verification/settings_tb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator and run it; the exit status is the result
cd "$(dirname "$0")" &&
rm -rf obj_dir &&
verilator --binary -f list.f --top-module settings_tb -o settings_sim &&
./obj_dir/settings_sim ||
exit 1

// File: verification/settings_tb.sv
`timescale 1ns/1ns
`default_nettype none

module settings_tb;
	import settings_pkg::*;

	localparam logic [7:0] VER_MAJOR = 8'h00;
	localparam logic [7:0] VER_MINOR = 8'h02;
	localparam int TIMEOUT = 200;
	// Idle bus cycles that let the longest command finish after a frame
	localparam int FRAME_GAP = 16;

	logic clk;
	logic rst;
	logic [7:0] in_data;
	logic in_data_valid;
	logic in_frame_valid;
	logic nak_request;
	logic out_credit;
	logic [23:0] gpio_read;
	wire [7:0] out_data;
	wire out_valid;
	wire out_last;
	wire [7:0] i2c_speed;
	wire [15:0] i2c_addr;
	wire [23:0] gpio_level;
	wire [23:0] gpio_direction;

	integer seed;
	// Last I2C values written by the set commands
	logic [7:0] speed_set;
	logic [15:0] addr_set;

	settings_top #(
		.VERSION_MAJOR(VER_MAJOR),
		.VERSION_MINOR(VER_MINOR),
		.FIFO_DEPTH(16)
	) DUT (
		.clk(clk), .rst(rst),
		.in_data(in_data), .in_data_valid(in_data_valid), .in_frame_valid(in_frame_valid),
		.nak_request(nak_request),
		.out_data(out_data), .out_valid(out_valid), .out_last(out_last),
		.out_credit(out_credit), .gpio_read(gpio_read),
		.i2c_speed(i2c_speed), .i2c_addr(i2c_addr),
		.gpio_level(gpio_level), .gpio_direction(gpio_direction)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Every drive and every sample happens 1 ns after a rising edge
	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "Simulation stopped on the first error");
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
			abort_run($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, want));
	endtask

	// Bytes are right aligned with the first bus byte most significant
	task automatic send_frame(input int n, input logic [63:0] bytes);
		int k;
		for (k = 0; k < n; k++) begin
			in_frame_valid = 1'b1;
			in_data_valid = 1'b1;
			in_data = 8'(bytes >> (8 * (n - 1 - k)));
			step();
		end
		in_frame_valid = 1'b0;
		in_data_valid = 1'b0;
		in_data = 8'h00;
		for (k = 0; k < FRAME_GAP; k++)
			step();
	endtask

	task automatic give_credit();
		out_credit = 1'b1;
		step();
		out_credit = 1'b0;
	endtask

	// Next byte on the stream followed by a quiet cycle
	task automatic expect_byte(input logic [7:0] want, input logic last);
		int t;
		t = 0;
		while (!out_valid) begin
			if (t == TIMEOUT)
				abort_run($sformatf("Timed out waiting for reply byte 0x%0h", want));
			step();
			t++;
		end
		check("out_data", 32'(out_data), 32'(want));
		check("out_last", 32'(out_last), 32'(last));
		step();
		check("out_valid", 32'(out_valid), 32'd0);
	endtask

	// One credit per byte and no byte without a credit
	task automatic expect_frame(input int n, input logic [39:0] bytes);
		int k;
		for (k = 0; k < n; k++) begin
			give_credit();
			expect_byte(8'(bytes >> (8 * (n - 1 - k))), k == n - 1);
		end
	endtask

	task automatic expect_silence(input int cycles);
		int k;
		for (k = 0; k < cycles; k++) begin
			check("out_valid", 32'(out_valid), 32'd0);
			step();
		end
	endtask

	task automatic wait_gpio(input logic [23:0] level, input logic [23:0] dir);
		int t;
		t = 0;
		while (gpio_level !== level || gpio_direction !== dir) begin
			if (t == TIMEOUT)
				abort_run("GPIO outputs never took the values of the last set command");
			step();
			t++;
		end
	endtask

	task automatic test_reset();
		check("i2c_speed", 32'(i2c_speed), 32'(I2C_SPEED_RESET));
		check("i2c_addr", 32'(i2c_addr), 32'(I2C_ADDR_RESET));
		check("gpio_level", 32'(gpio_level), 32'(GPIO_RESET));
		check("gpio_direction", 32'(gpio_direction), 32'(GPIO_RESET));
		expect_silence(20);
	endtask

	task automatic test_version();
		logic [7:0] eid;
		eid = 8'($random(seed));
		send_frame(5, 64'({CMD_VERSION, eid, 8'd2, VER_MAJOR, VER_MINOR}));
		expect_frame(2, 40'({ACK_CODE, eid}));
		eid = 8'($random(seed));
		send_frame(5, 64'({CMD_VERSION, eid, 8'd2, VER_MAJOR ^ 8'h01, VER_MINOR}));
		expect_frame(2, 40'({NAK_CODE, eid}));
		expect_frame(2, 40'({VER_MAJOR, VER_MINOR}));
	endtask

	task automatic test_i2c();
		logic [7:0] eid;
		logic [7:0] speed;
		logic [15:0] addr;
		speed = 8'($random(seed));
		addr = 16'($random(seed));
		speed_set = speed;
		addr_set = addr;
		eid = 8'($random(seed));
		send_frame(5, 64'({CMD_SET_I2C, eid, 8'd2, SEL_I2C_SPEED, speed}));
		expect_frame(2, 40'({ACK_CODE, eid}));
		check("i2c_speed", 32'(i2c_speed), 32'(speed));
		eid = 8'($random(seed));
		send_frame(6, 64'({CMD_SET_I2C, eid, 8'd3, SEL_I2C_ADDR, addr}));
		expect_frame(2, 40'({ACK_CODE, eid}));
		check("i2c_addr", 32'(i2c_addr), 32'(addr));
		eid = 8'($random(seed));
		send_frame(4, 64'({CMD_QUERY_I2C, eid, 8'd1, SEL_I2C_SPEED}));
		expect_frame(2, 40'({ACK_CODE, eid}));
		expect_frame(1, 40'(speed));
		eid = 8'($random(seed));
		send_frame(4, 64'({CMD_QUERY_I2C, eid, 8'd1, SEL_I2C_ADDR}));
		expect_frame(2, 40'({ACK_CODE, eid}));
		expect_frame(2, 40'(addr));
	endtask

	task automatic test_gpio();
		logic [7:0] eid;
		logic [23:0] level;
		logic [23:0] dir;
		level = 24'($random(seed));
		dir = 24'($random(seed));
		eid = 8'($random(seed));
		send_frame(7, 64'({CMD_SET_GPIO, eid, 8'd4, SEL_GPIO_LEVEL, level}));
		// ACK still waits in the FIFO, so the old level must hold
		check("gpio_level", 32'(gpio_level), 32'(GPIO_RESET));
		expect_frame(2, 40'({ACK_CODE, eid}));
		wait_gpio(level, GPIO_RESET);
		eid = 8'($random(seed));
		send_frame(7, 64'({CMD_SET_GPIO, eid, 8'd4, SEL_GPIO_DIR, dir}));
		check("gpio_direction", 32'(gpio_direction), 32'(GPIO_RESET));
		expect_frame(2, 40'({ACK_CODE, eid}));
		wait_gpio(level, dir);
		eid = 8'($random(seed));
		send_frame(4, 64'({CMD_QUERY_GPIO, eid, 8'd1, SEL_GPIO_DIR}));
		expect_frame(2, 40'({ACK_CODE, eid}));
		expect_frame(3, 40'(dir));
		// Level queries report the pins, not the level register
		gpio_read = 24'($random(seed));
		eid = 8'($random(seed));
		send_frame(4, 64'({CMD_QUERY_GPIO, eid, 8'd1, SEL_GPIO_LEVEL}));
		expect_frame(2, 40'({ACK_CODE, eid}));
		expect_frame(3, 40'(gpio_read));
	endtask

	task automatic test_nak_unknown();
		logic [7:0] eid;
		eid = 8'($random(seed));
		nak_request = 1'b1;
		step();
		nak_request = 1'b0;
		send_frame(4, 64'({CMD_QUERY_I2C, eid, 8'd1, SEL_I2C_SPEED}));
		expect_frame(2, 40'({NAK_CODE, eid}));
		// A spare credit lets any unwanted reply show up on the stream
		give_credit();
		expect_silence(20);
		eid = 8'($random(seed));
		fork
			send_frame(3, 64'({8'h55, eid, 8'd0}));
			expect_silence(50);
		join
		// Spare credit carries the first byte of this reply
		eid = 8'($random(seed));
		fork
			send_frame(5, 64'({CMD_VERSION, eid, 8'd2, VER_MAJOR, VER_MINOR}));
			expect_byte(ACK_CODE, 1'b0);
		join
		expect_frame(1, 40'(eid));
	endtask

	task automatic test_backpressure();
		logic [7:0] eid_a;
		logic [7:0] eid_b;
		eid_a = 8'($random(seed));
		eid_b = 8'($random(seed));
		send_frame(4, 64'({CMD_QUERY_I2C, eid_a, 8'd1, SEL_I2C_SPEED}));
		send_frame(4, 64'({CMD_QUERY_I2C, eid_b, 8'd1, SEL_I2C_ADDR}));
		expect_silence(30);
		expect_frame(2, 40'({ACK_CODE, eid_a}));
		expect_frame(1, 40'(speed_set));
		expect_frame(2, 40'({ACK_CODE, eid_b}));
		expect_frame(2, 40'(addr_set));
	endtask

	initial begin
		seed = 32'hd099490f;
		rst = 1'b1;
		in_data = 8'h00;
		in_data_valid = 1'b0;
		in_frame_valid = 1'b0;
		nak_request = 1'b0;
		out_credit = 1'b0;
		gpio_read = 24'h000000;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		step();
		test_reset();
		test_version();
		test_i2c();
		test_gpio();
		test_nak_unknown();
		test_backpressure();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire
